// File: bench/decodeModel.svh
// Reference decode rules for the testbench, included into decodeTb to predict each control word
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Expected control word of one valid instruction, zero for anything illegal
function automatic controlWord expectedControl(input logic [31:0] word);
    controlWord c;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    c   = '0;
    opc = word[6:0];
    f3  = word[14:12];
    f7  = word[31:25];
    case (opc)
        // Register ALU operations
        7'b0110011: begin
            c.regWrite = 1'b1;
            if (f7 == 7'h00) begin
                case (f3)
                    3'd0: c.aluOp = add;
                    3'd1: c.aluOp = sll;
                    3'd2: c.aluOp = slt;
                    3'd3: c.aluOp = sltu;
                    3'd4: c.aluOp = opXor;
                    3'd5: c.aluOp = srl;
                    3'd6: c.aluOp = opOr;
                    3'd7: c.aluOp = opAnd;
                endcase
            end else if (f7 == 7'h20 && f3 == 3'd0) begin
                c.aluOp = sub;
            end else if (f7 == 7'h20 && f3 == 3'd5) begin
                c.aluOp = sra;
            end else begin
                c = '0;
            end
        end
        // Immediate ALU operations and shifts
        7'b0010011: begin
            c.regWrite = 1'b1;
            c.aluSrcB  = srcImm;
            c.immSrc   = immI;
            case (f3)
                3'd0: c.aluOp = add;
                3'd2: c.aluOp = slt;
                3'd3: c.aluOp = sltu;
                3'd4: c.aluOp = opXor;
                3'd6: c.aluOp = opOr;
                3'd7: c.aluOp = opAnd;
                3'd1: begin
                    c.immSrc = immShamt;
                    c.aluOp  = sll;
                    if (f7 != 7'h00) begin
                        c = '0;
                    end
                end
                default: begin
                    c.immSrc = immShamt;
                    if (f7 == 7'h00) begin
                        c.aluOp = srl;
                    end else if (f7 == 7'h20) begin
                        c.aluOp = sra;
                    end else begin
                        c = '0;
                    end
                end
            endcase
        end
        7'b0000011: begin
            c.regWrite  = 1'b1;
            c.memEn     = 1'b1;
            c.aluSrcB   = srcImm;
            c.resultSrc = fromMemory;
            case (f3)
                3'd0: c.truncSrc = truncByte;
                3'd1: c.truncSrc = truncHalf;
                3'd2: c.truncSrc = truncWord;
                3'd4: c.truncSrc = truncByteU;
                3'd5: c.truncSrc = truncHalfU;
                default: c = '0;
            endcase
        end
        7'b0100011: begin
            c.memEn      = 1'b1;
            c.memWriteEn = 1'b1;
            c.immSrc     = immS;
            c.miscSrc    = writeData;
            c.aluSrcB    = srcImm;
            case (f3)
                3'd0: c.memByteEn = 4'h1;
                3'd1: c.memByteEn = 4'h3;
                3'd2: c.memByteEn = 4'hF;
                default: c = '0;
            endcase
        end
        7'b0110111, 7'b0010111: begin
            c.regWrite   = 1'b1;
            c.immSrc     = immU;
            c.computeSrc = computeMisc;
            c.miscSrc    = (opc == 7'b0010111) ? pcPlusImm : loadImm;
        end
        // Jumps link the return address
        7'b1101111, 7'b1100111: begin
            c.regWrite   = 1'b1;
            c.computeSrc = computeMisc;
            c.miscSrc    = linkPcPlus4;
            if (opc == 7'b1101111) begin
                c.pcSrc  = jumpRel;
                c.immSrc = immJ;
            end else begin
                c.pcSrc   = jumpReg;
                c.aluSrcB = srcImm;
            end
        end
        7'b1100011: begin
            c.pcSrc  = pcBranch;
            c.immSrc = immB;
            c.aluOp  = sub;
            case (f3)
                3'd0: c.branchCond = beq;
                3'd1: c.branchCond = bne;
                3'd4: c.branchCond = blt;
                3'd5: c.branchCond = bge;
                3'd6: c.branchCond = bltu;
                3'd7: c.branchCond = bgeu;
                default: c = '0;
            endcase
        end
        default: c = '0;
    endcase
    return c;
endfunction

`endif

// File: bench/decodeTb.sv
// Testbench for decodeStage that drives directed and random instructions and checks each control word
module decodeTb
    import decodePkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RandomCount = 400;

    logic                   clk;
    logic                   reset;
    logic [InstrWidth-1:0]  instr;
    logic                   instrValid;
    logic                   ctrlValid;
    pcSel                   pcSrc;
    branchKind              branchCond;
    immKind                 immSrc;
    miscSel                 miscSrc;
    aluSrcKind              aluSrcB;
    aluOpKind               aluOp;
    computeSel              computeSrc;
    resultSel               resultSrc;
    truncKind               truncSrc;
    logic                   regWrite;
    logic                   memEn;
    logic                   memWriteEn;
    logic [ByteEnWidth-1:0] memByteEn;

    logic [31:0] stimInstr[$];
    logic        stimValid[$];
    logic        vectorsReady;
    logic [31:0] lcgState;

    logic [6:0] legalOps [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h37, 7'h17, 7'h6F, 7'h67, 7'h63};

    decodeStage dut_i (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .instrValid (instrValid),
        .ctrlValid  (ctrlValid),
        .pcSrc      (pcSrc),
        .branchCond (branchCond),
        .immSrc     (immSrc),
        .miscSrc    (miscSrc),
        .aluSrcB    (aluSrcB),
        .aluOp      (aluOp),
        .computeSrc (computeSrc),
        .resultSrc  (resultSrc),
        .truncSrc   (truncSrc),
        .regWrite   (regWrite),
        .memEn      (memEn),
        .memWriteEn (memWriteEn),
        .memByteEn  (memByteEn)
    );

    `include "decodeModel.svh"

    always #10 clk = ~clk;

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] makeInstr(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [6:0] op);
        return {f7, 5'd6, 5'd5, f3, 5'd4, op};
    endfunction

    task automatic addVector(input logic [31:0] word, input logic valid);
        stimInstr.push_back(word);
        stimValid.push_back(valid);
    endtask

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic buildVectors();
        logic [31:0] word;
        logic [31:0] r;
        // Every funct3 of each format including the illegal ones
        for (int f = 0; f < 8; f++) begin
            addVector(makeInstr(7'h00, f[2:0], 7'h33), 1'b1);
            addVector(makeInstr(7'h00, f[2:0], 7'h13), 1'b1);
            addVector(makeInstr(7'h2A, f[2:0], 7'h03), 1'b1);
            addVector(makeInstr(7'h15, f[2:0], 7'h23), 1'b1);
            addVector(makeInstr(7'h40, f[2:0], 7'h63), 1'b1);
        end
        addVector(makeInstr(7'h20, 3'd0, 7'h33), 1'b1);
        addVector(makeInstr(7'h20, 3'd5, 7'h33), 1'b1);
        addVector(makeInstr(7'h01, 3'd0, 7'h33), 1'b1);
        addVector(makeInstr(7'h20, 3'd1, 7'h33), 1'b1);
        addVector(makeInstr(7'h20, 3'd5, 7'h13), 1'b1);
        addVector(makeInstr(7'h20, 3'd1, 7'h13), 1'b1);
        addVector(makeInstr(7'h10, 3'd5, 7'h13), 1'b1);
        addVector(makeInstr(7'h55, 3'd0, 7'h13), 1'b1);
        addVector(makeInstr(7'h12, 3'd3, 7'h37), 1'b1);
        addVector(makeInstr(7'h34, 3'd6, 7'h17), 1'b1);
        addVector(makeInstr(7'h7F, 3'd2, 7'h6F), 1'b1);
        addVector(makeInstr(7'h00, 3'd0, 7'h67), 1'b1);
        // Opcodes outside the base set
        addVector(makeInstr(7'h00, 3'd0, 7'h7F), 1'b1);
        addVector(makeInstr(7'h00, 3'd0, 7'h0F), 1'b1);
        addVector(makeInstr(7'h00, 3'd0, 7'h73), 1'b1);
        addVector(makeInstr(7'h00, 3'd0, 7'h3B), 1'b1);
        addVector(32'h0000_0000, 1'b1);
        addVector(makeInstr(7'h00, 3'd0, 7'h33), 1'b0);
        for (int i = 0; i < RandomCount; i++) begin
            word = lcgNext();
            r    = lcgNext();
            if (r[31]) begin
                word[6:0] = legalOps[r[27:24] % 9];
                if (r[23]) begin
                    word[31:25] = r[22] ? 7'h20 : 7'h00;
                end
            end
            addVector(word, r[30:29] != 2'b00);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        instr        = makeInstr(7'h00, 3'd0, 7'h33);
        instrValid   = 1'b1;
        lcgState     = 32'd31;
        vectorsReady = 1'b0;
        buildVectors();
        vectorsReady = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        foreach (stimInstr[i]) begin
            instr      = stimInstr[i];
            instrValid = stimValid[i];
            @(posedge clk);
            #2;
        end
        instrValid = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        $display("Test OK");
        $finish;
    end

    // Inputs seen at the edge predict the outputs just after it
    initial begin : compareOutputs
        logic [31:0] sampledInstr;
        logic        sampledValid;
        logic        sampledReset;
        logic        expValid;
        controlWord  exp;
        forever begin
            @(posedge clk);
            sampledInstr = instr;
            sampledValid = instrValid;
            sampledReset = reset;
            #1;
            expValid = !sampledReset && sampledValid;
            if (expValid) begin
                exp = expectedControl(sampledInstr);
            end else begin
                exp = '0;
            end
            checkField("ctrlValid", ctrlValid, expValid);
            checkField("pcSrc", pcSrc, exp.pcSrc);
            checkField("branchCond", branchCond, exp.branchCond);
            checkField("immSrc", immSrc, exp.immSrc);
            checkField("miscSrc", miscSrc, exp.miscSrc);
            checkField("aluSrcB", aluSrcB, exp.aluSrcB);
            checkField("aluOp", aluOp, exp.aluOp);
            checkField("computeSrc", computeSrc, exp.computeSrc);
            checkField("resultSrc", resultSrc, exp.resultSrc);
            checkField("truncSrc", truncSrc, exp.truncSrc);
            checkField("regWrite", regWrite, exp.regWrite);
            checkField("memEn", memEn, exp.memEn);
            checkField("memWriteEn", memWriteEn, exp.memWriteEn);
            checkField("memByteEn", memByteEn, exp.memByteEn);
        end
    end

    initial begin
        wait (vectorsReady);
        #((stimInstr.size() + 10) * 40);
        $display("Timeout: the test did not finish within the expected run time");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

// File: common/decodePkg.sv
// Shared field widths, opcode and funct constants and control word types for the decode stage
package decodePkg;

    // Instruction word and field widths
    localparam int InstrWidth  = 32;
    localparam int OpcodeWidth = 7;
    localparam int Funct3Width = 3;
    localparam int Funct7Width = 7;
    localparam int ByteEnWidth = InstrWidth / 8;

    // Major opcodes of the base integer set
    typedef enum logic [OpcodeWidth-1:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011
    } opcodeKind;

    // The only two legal funct7 patterns
    localparam logic [Funct7Width-1:0] funct7Base = 7'b0000000;
    localparam logic [Funct7Width-1:0] funct7Alt  = 7'b0100000;

    // Next PC source
    typedef enum logic [1:0] {
        pcPlus4,
        jumpRel,
        jumpReg,
        pcBranch
    } pcSel;

    // Condition evaluated by the branch unit
    typedef enum logic [2:0] {
        noBranch,
        beq,
        bne,
        blt,
        bge,
        bltu,
        bgeu
    } branchKind;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ,
        immShamt
    } immKind;

    // Value routed through the misc path
    typedef enum logic [1:0] {
        loadImm,
        pcPlusImm,
        linkPcPlus4,
        writeData
    } miscSel;

    typedef enum logic {
        srcRs2,
        srcImm
    } aluSrcKind;

    typedef enum logic [3:0] {
        add,
        sub,
        opOr,
        opAnd,
        opXor,
        sll,
        slt,
        sltu,
        srl,
        sra
    } aluOpKind;

    typedef enum logic {
        computeAlu,
        computeMisc
    } computeSel;

    typedef enum logic {
        fromCompute,
        fromMemory
    } resultSel;

    // Load data truncation and extension
    typedef enum logic [2:0] {
        noTrunc,
        truncByte,
        truncHalf,
        truncWord,
        truncByteU,
        truncHalfU
    } truncKind;

    // Full control word, 27 bits
    typedef struct packed {
        pcSel                   pcSrc;
        branchKind              branchCond;
        immKind                 immSrc;
        miscSel                 miscSrc;
        aluSrcKind              aluSrcB;
        aluOpKind               aluOp;
        computeSel              computeSrc;
        logic                   regWrite;
        logic                   memEn;
        logic                   memWriteEn;
        logic [ByteEnWidth-1:0] memByteEn;
        resultSel               resultSrc;
        truncKind               truncSrc;
    } controlWord;

    // Bubble and illegal instruction, writes nothing and never branches
    localparam controlWord bubbleWord = '0;

endpackage

// File: decoder/aluDecoder.sv
// Decodes register and immediate ALU instructions into a control word, used by instrDecoder
module aluDecoder
    import decodePkg::*;
(
    input  logic [Funct3Width-1:0] funct3,
    input  logic [Funct7Width-1:0] funct7,
    input  opcodeKind              opcode,
    output controlWord             ctrl
);

    logic     isImm;
    logic     legal;
    aluOpKind op;
    immKind   imm;

    assign isImm = (opcode == opImm);

    always_comb begin
        legal = 1'b1;
        op    = add;
        imm   = immI;
        if (!isImm) begin
            // Register form, funct7 and funct3 together
            case ({funct7, funct3})
                {funct7Base, 3'b000}: op = add;
                {funct7Alt,  3'b000}: op = sub;
                {funct7Base, 3'b001}: op = sll;
                {funct7Base, 3'b010}: op = slt;
                {funct7Base, 3'b011}: op = sltu;
                {funct7Base, 3'b100}: op = opXor;
                {funct7Base, 3'b101}: op = srl;
                {funct7Alt,  3'b101}: op = sra;
                {funct7Base, 3'b110}: op = opOr;
                {funct7Base, 3'b111}: op = opAnd;
                default:              legal = 1'b0;
            endcase
        end else begin
            case (funct3)
                3'b000: op = add;
                3'b010: op = slt;
                3'b011: op = sltu;
                3'b100: op = opXor;
                3'b110: op = opOr;
                3'b111: op = opAnd;
                // Shift amount sits in the rs2 slot, funct7 still checked
                3'b001: begin
                    imm   = immShamt;
                    op    = sll;
                    legal = (funct7 == funct7Base);
                end
                3'b101: begin
                    imm = immShamt;
                    if (funct7 == funct7Base) begin
                        op = srl;
                    end else if (funct7 == funct7Alt) begin
                        op = sra;
                    end else begin
                        legal = 1'b0;
                    end
                end
                default: legal = 1'b0;
            endcase
        end
    end

    always_comb begin
        ctrl = bubbleWord;
        if (legal) begin
            ctrl.pcSrc      = pcPlus4;
            ctrl.aluOp      = op;
            ctrl.computeSrc = computeAlu;
            ctrl.resultSrc  = fromCompute;
            ctrl.regWrite   = 1'b1;
            if (isImm) begin
                ctrl.immSrc  = imm;
                ctrl.aluSrcB = srcImm;
            end else begin
                ctrl.aluSrcB = srcRs2;
            end
        end
    end

endmodule

// File: decoder/flowDecoder.sv
// Decodes upper immediates, jumps and conditional branches into a control word for instrDecoder
module flowDecoder
    import decodePkg::*;
(
    input  logic [Funct3Width-1:0] funct3,
    input  opcodeKind              opcode,
    output controlWord             ctrl
);

    always_comb begin
        ctrl = bubbleWord;
        case (opcode)
            opLui: begin
                ctrl.regWrite   = 1'b1;
                ctrl.immSrc     = immU;
                ctrl.miscSrc    = loadImm;
                ctrl.computeSrc = computeMisc;
            end
            opAuipc: begin
                ctrl.regWrite   = 1'b1;
                ctrl.immSrc     = immU;
                ctrl.miscSrc    = pcPlusImm;
                ctrl.computeSrc = computeMisc;
            end
            // Jumps write the return address to rd
            opJal: begin
                ctrl.regWrite   = 1'b1;
                ctrl.pcSrc      = jumpRel;
                ctrl.immSrc     = immJ;
                ctrl.miscSrc    = linkPcPlus4;
                ctrl.computeSrc = computeMisc;
            end
            opJalr: begin
                ctrl.regWrite   = 1'b1;
                ctrl.pcSrc      = jumpReg;
                ctrl.immSrc     = immI;
                ctrl.aluSrcB    = srcImm;
                ctrl.aluOp      = add;
                ctrl.miscSrc    = linkPcPlus4;
                ctrl.computeSrc = computeMisc;
            end
            default: begin
                // Conditional branch, rs1 minus rs2 feeds the compare
                ctrl.pcSrc   = pcBranch;
                ctrl.immSrc  = immB;
                ctrl.aluSrcB = srcRs2;
                ctrl.aluOp   = sub;
                case (funct3)
                    3'b000:  ctrl.branchCond = beq;
                    3'b001:  ctrl.branchCond = bne;
                    3'b100:  ctrl.branchCond = blt;
                    3'b101:  ctrl.branchCond = bge;
                    3'b110:  ctrl.branchCond = bltu;
                    3'b111:  ctrl.branchCond = bgeu;
                    default: ctrl = bubbleWord;
                endcase
            end
        endcase
    end

endmodule

// File: decoder/instrDecoder.sv
// Splits an instruction word into fields and picks the control word of the owning format decoder
module instrDecoder
    import decodePkg::*;
(
    input  logic [InstrWidth-1:0] instr,
    output controlWord            ctrl
);

    opcodeKind              opcode;
    logic [Funct3Width-1:0] funct3;
    logic [Funct7Width-1:0] funct7;

    controlWord aluCtrl;
    controlWord memCtrl;
    controlWord flowCtrl;

    // Fixed field positions of the base formats
    assign opcode = opcodeKind'(instr[OpcodeWidth-1:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[InstrWidth-1 -: Funct7Width];

    aluDecoder aluDec_i (
        .funct3 (funct3),
        .funct7 (funct7),
        .opcode (opcode),
        .ctrl   (aluCtrl)
    );

    memDecoder memDec_i (
        .funct3 (funct3),
        .opcode (opcode),
        .ctrl   (memCtrl)
    );

    flowDecoder flowDec_i (
        .funct3 (funct3),
        .opcode (opcode),
        .ctrl   (flowCtrl)
    );

    // Opcode legality is decided here only
    always_comb begin
        case (opcode)
            opReg,
            opImm:    ctrl = aluCtrl;
            opLoad,
            opStore:  ctrl = memCtrl;
            opLui,
            opAuipc,
            opJal,
            opJalr,
            opBranch: ctrl = flowCtrl;
            default:  ctrl = bubbleWord;
        endcase
    end

endmodule

// File: decoder/memDecoder.sv
// Decodes load and store instructions into a control word, used by instrDecoder
module memDecoder
    import decodePkg::*;
(
    input  logic [Funct3Width-1:0] funct3,
    input  opcodeKind              opcode,
    output controlWord             ctrl
);

    logic isStore;

    assign isStore = (opcode == opStore);

    always_comb begin
        ctrl = bubbleWord;
        if (isStore) begin
            // Address is rs1 plus the split S immediate
            ctrl.memEn      = 1'b1;
            ctrl.memWriteEn = 1'b1;
            ctrl.immSrc     = immS;
            ctrl.miscSrc    = writeData;
            ctrl.aluSrcB    = srcImm;
            ctrl.aluOp      = add;
            case (funct3)
                3'b000:  ctrl.memByteEn = 4'b0001;
                3'b001:  ctrl.memByteEn = 4'b0011;
                3'b010:  ctrl.memByteEn = 4'b1111;
                default: ctrl = bubbleWord;
            endcase
        end else begin
            ctrl.regWrite  = 1'b1;
            ctrl.memEn     = 1'b1;
            ctrl.immSrc    = immI;
            ctrl.aluSrcB   = srcImm;
            ctrl.aluOp     = add;
            ctrl.resultSrc = fromMemory;
            // Width and sign of the loaded value
            case (funct3)
                3'b000:  ctrl.truncSrc = truncByte;
                3'b001:  ctrl.truncSrc = truncHalf;
                3'b010:  ctrl.truncSrc = truncWord;
                3'b100:  ctrl.truncSrc = truncByteU;
                3'b101:  ctrl.truncSrc = truncHalfU;
                default: ctrl = bubbleWord;
            endcase
        end
    end

endmodule

// File: files.f
+incdir+bench
common/decodePkg.sv
decoder/aluDecoder.sv
decoder/memDecoder.sv
decoder/flowDecoder.sv
decoder/instrDecoder.sv
logic/decodeStage.sv
bench/decodeTb.sv

// File: logic/decodeStage.sv
// Decode stage top level, registers the decoded control word one cycle after the instruction
module decodeStage
    import decodePkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [InstrWidth-1:0]  instr,
    input  logic                   instrValid,
    output logic                   ctrlValid,
    output pcSel                   pcSrc,
    output branchKind              branchCond,
    output immKind                 immSrc,
    output miscSel                 miscSrc,
    output aluSrcKind              aluSrcB,
    output aluOpKind               aluOp,
    output computeSel              computeSrc,
    output resultSel               resultSrc,
    output truncKind               truncSrc,
    output logic                   regWrite,
    output logic                   memEn,
    output logic                   memWriteEn,
    output logic [ByteEnWidth-1:0] memByteEn
);

    controlWord decoded;
    controlWord ctrlReg;

    instrDecoder instrDec_i (
        .instr (instr),
        .ctrl  (decoded)
    );

    // A bubble loads the zero word so nothing stale reaches execute
    always_ff @(posedge clk) begin
        if (reset || !instrValid) begin
            ctrlReg   <= bubbleWord;
            ctrlValid <= 1'b0;
        end else begin
            ctrlReg   <= decoded;
            ctrlValid <= 1'b1;
        end
    end

    assign pcSrc      = ctrlReg.pcSrc;
    assign branchCond = ctrlReg.branchCond;
    assign immSrc     = ctrlReg.immSrc;
    assign miscSrc    = ctrlReg.miscSrc;
    assign aluSrcB    = ctrlReg.aluSrcB;
    assign aluOp      = ctrlReg.aluOp;
    assign computeSrc = ctrlReg.computeSrc;
    assign resultSrc  = ctrlReg.resultSrc;
    assign truncSrc   = ctrlReg.truncSrc;
    assign regWrite   = ctrlReg.regWrite;
    assign memEn      = ctrlReg.memEn;
    assign memWriteEn = ctrlReg.memWriteEn;
    assign memByteEn  = ctrlReg.memByteEn;

    // A write always enables the memory port
    memWriteNeedsEn: assert property (@(posedge clk) disable iff (reset)
        memWriteEn |-> memEn);

    // Byte lanes only matter for stores
    byteEnOnlyOnWrite: assert property (@(posedge clk) disable iff (reset)
        (memByteEn != '0) |-> memWriteEn);

    // Register writers and the store path never claim the same instruction
    noRegWriteOnStore: assert property (@(posedge clk) disable iff (reset)
        !(regWrite && memWriteEn));

endmodule
